/* filelist.f */
fu_pkg.sv
fu_issue_decode.sv
cond_check.sv
alu_exec.sv
ls_exec.sv
fu_writeback.sv
func_units.sv
func_units_assertions.sv
tb_func_units.sv

/* Bender.yml */
package:
  name: func_units

sources:
  - fu_pkg.sv
  - fu_issue_decode.sv
  - cond_check.sv
  - alu_exec.sv
  - ls_exec.sv
  - fu_writeback.sv
  - func_units.sv
  - target: test
    files:
      - func_units_assertions.sv
      - tb_func_units.sv

/* tb_func_units.sv */
`timescale 1ns/1ps

module tb_func_units;
  import fu_pkg::*;

  logic     clk;
  logic     rst_n;
  logic     alu_start;
  fu_op_t   alu_op;
  gpr_t     alu_val_a;
  gpr_t     alu_val_b;
  rob_idx_t alu_dst;
  logic     alu_set_nzcv;
  nzcv_t    alu_nzcv;
  cond_t    alu_cond;
  logic     ls_start;
  fu_op_t   ls_op;
  gpr_t     ls_val_a;
  gpr_t     ls_val_b;
  rob_idx_t ls_dst;
  logic     alu_ready;
  logic     ls_ready;
  logic     rob_done;
  rob_idx_t rob_dst;
  gpr_t     rob_value;
  nzcv_t    rob_nzcv;
  logic     rob_set_nzcv;
  logic     rob_cond;

  integer seed = 32'h6562;
  int     checks = 0;
  int     errors = 0;
  int     test_base = 0;

  func_units u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic compare(input string name, input logic [63:0] expected, input logic [63:0] got);
    checks++;
    if (got !== expected) begin
      $display("Error %s expected 0x%0h got 0x%0h", name, expected, got);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("%-12s done, %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  // ARM condition table, odd codes invert the even ones
  function automatic logic cond_model(input cond_t cond, input nzcv_t f);
    logic r;
    case (cond[3:1])
      3'd0: r = f[2];
      3'd1: r = f[1];
      3'd2: r = f[3];
      3'd3: r = f[0];
      3'd4: r = f[1] && !f[2];
      3'd5: r = (f[3] == f[0]);
      3'd6: r = !f[2] && (f[3] == f[0]);
      default: r = 1'b1;
    endcase
    if (cond[0] && cond != 4'hf) r = !r;
    return r;
  endfunction

  task automatic wait_done();
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < 20 && !seen; n++) begin
      @(negedge clk);
      seen = rob_done;
    end
    if (!seen) begin
      $display("Timeout: rob_done did not rise within 20 cycles");
      errors++;
    end
  endtask

  task automatic set_alu(input fu_op_t op, input gpr_t a, input gpr_t b, input rob_idx_t dst,
                         input logic set, input nzcv_t nz, input cond_t cond);
    alu_op = op;
    alu_val_a = a;
    alu_val_b = b;
    alu_dst = dst;
    alu_set_nzcv = set;
    alu_nzcv = nz;
    alu_cond = cond;
    alu_start = 1'b1;
  endtask

  task automatic set_ls(input fu_op_t op, input gpr_t addr, input gpr_t data, input rob_idx_t dst);
    ls_op = op;
    ls_val_a = addr;
    ls_val_b = data;
    ls_dst = dst;
    ls_start = 1'b1;
  endtask

  task automatic run_alu(input fu_op_t op, input gpr_t a, input gpr_t b, input rob_idx_t dst,
                         input logic set, input nzcv_t nz, input cond_t cond);
    logic [64:0] wide;
    gpr_t  val;
    logic  c;
    logic  v;
    logic  holds;
    holds = cond_model(cond, nz);
    c = 1'b0;
    v = 1'b0;
    case (op)
      FU_OP_PLUS: begin
        wide = {1'b0, a} + {1'b0, b};
        val = wide[63:0];
        c = wide[64];
        v = (a[63] == b[63]) && (val[63] != a[63]);
      end
      FU_OP_MINUS: begin
        val = a - b;
        c = (a >= b);
        v = (a[63] != b[63]) && (val[63] != a[63]);
      end
      FU_OP_AND: val = a & b;
      FU_OP_OR, FU_OP_MOV: val = a | b;
      FU_OP_ORN: val = a | ~b;
      FU_OP_EOR: val = a ^ b;
      FU_OP_CSEL: val = holds ? a : b;
      FU_OP_CSINC: val = holds ? a : b + 64'd1;
      FU_OP_CSINV: val = holds ? a : ~b;
      FU_OP_CSNEG: val = holds ? a : -b;
      default: val = '0;
    endcase
    @(negedge clk);
    set_alu(op, a, b, dst, set, nz, cond);
    @(negedge clk);
    alu_start = 1'b0;
    wait_done();
    compare("rob_dst", dst, rob_dst);
    compare("rob_value", val, rob_value);
    compare("rob_nzcv", set ? {val[63], val == 64'd0, c, v} : nz, rob_nzcv);
    compare("rob_set_nzcv", set, rob_set_nzcv);
    compare("rob_cond", holds, rob_cond);
  endtask

  task automatic run_ls(input fu_op_t op, input gpr_t addr, input gpr_t data, input rob_idx_t dst,
                        input gpr_t expected);
    @(negedge clk);
    set_ls(op, addr, data, dst);
    @(negedge clk);
    ls_start = 1'b0;
    wait_done();
    compare("rob_dst", dst, rob_dst);
    compare("rob_value", expected, rob_value);
    compare("rob_nzcv", 0, rob_nzcv);
    compare("rob_set_nzcv", 0, rob_set_nzcv);
  endtask

  task automatic test_arith();
    fu_op_t ops[7] = '{FU_OP_PLUS, FU_OP_MINUS, FU_OP_AND, FU_OP_OR, FU_OP_ORN, FU_OP_EOR,
                       FU_OP_MOV};
    gpr_t   a[14] = '{64'hffff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000,
                      64'd0, 64'h8000_0000_0000_0000, 64'd5, 0, 0, 0, 0, 0, 0, 0, 0};
    gpr_t   b[14] = '{64'd1, 64'd1, 64'h8000_0000_0000_0000, 64'd1, 64'd1, 64'd5,
                      0, 0, 0, 0, 0, 0, 0, 0};
    // Carry and overflow corners first, then random pairs
    for (int i = 6; i < 14; i++) begin
      a[i] = {$random(seed), $random(seed)};
      b[i] = {$random(seed), $random(seed)};
    end
    for (int i = 0; i < 14; i++) begin
      foreach (ops[k]) run_alu(ops[k], a[i], b[i], rob_idx_t'(i + k), 1'b1, 4'h0, COND_AL);
    end
    finish_test("arith");
  endtask

  task automatic test_flag_pass();
    for (int i = 0; i < 16; i++) begin
      run_alu(i[0] ? FU_OP_MINUS : FU_OP_PLUS, {$random(seed), $random(seed)}, 64'(i),
              rob_idx_t'(i), 1'b0, nzcv_t'(i), COND_AL);
    end
    finish_test("flag_pass");
  endtask

  task automatic test_csel();
    nzcv_t  flags[6] = '{4'b0000, 4'b0100, 4'b0010, 4'b1001, 4'b1000, 4'b0001};
    fu_op_t ops[4] = '{FU_OP_CSEL, FU_OP_CSINC, FU_OP_CSINV, FU_OP_CSNEG};
    for (int c = 0; c < 15; c++) begin
      foreach (flags[f]) begin
        foreach (ops[k]) begin
          run_alu(ops[k], {$random(seed), $random(seed)}, {$random(seed), $random(seed)},
                  rob_idx_t'(c + k), 1'b0, flags[f], cond_t'(c));
        end
      end
    end
    finish_test("csel");
  endtask

  task automatic test_memory();
    // Last address wraps around the end of memory
    gpr_t addrs[4] = '{64'h010, 64'h123, 64'h800, 64'hffd};
    gpr_t data[4];
    foreach (addrs[i]) begin
      data[i] = {$random(seed), $random(seed)};
      run_ls(FU_OP_STUR, addrs[i], data[i], rob_idx_t'(40 + i), data[i]);
    end
    foreach (addrs[i]) run_ls(FU_OP_LDUR, addrs[i], 64'd0, rob_idx_t'(50 + i), data[i]);
    finish_test("memory");
  endtask

  task automatic test_pipeline();
    gpr_t a[4];
    gpr_t exp_val[4];
    for (int i = 0; i < 4; i++) a[i] = {$random(seed), $random(seed)};
    // Alternate ALU and store starts on consecutive cycles
    for (int i = 0; i < 7; i++) begin
      @(negedge clk);
      compare("rob_done", (i >= 2 && i < 6), rob_done);
      if (i >= 2 && i < 6) begin
        compare("rob_dst", 30 + i - 2, rob_dst);
        compare("rob_value", exp_val[i-2], rob_value);
      end
      alu_start = 1'b0;
      ls_start = 1'b0;
      if (i < 4 && !i[0]) begin
        set_alu(FU_OP_EOR, a[i], 64'h0f0f, rob_idx_t'(30 + i), 1'b1, 4'h0, COND_AL);
        exp_val[i] = a[i] ^ 64'h0f0f;
      end else if (i < 4) begin
        set_ls(FU_OP_STUR, 64'h200 + 8 * i, a[i], rob_idx_t'(30 + i));
        exp_val[i] = a[i];
      end
    end
    finish_test("pipeline");
  endtask

  task automatic test_arbitration();
    @(negedge clk);
    set_ls(FU_OP_STUR, 64'h300, 64'h1122_3344_5566_7788, 6'd20);
    set_alu(FU_OP_PLUS, 64'd7, 64'd9, 6'd21, 1'b1, 4'h0, COND_AL);
    #10;
    compare("alu_ready", 0, alu_ready);
    compare("ls_ready", 1, ls_ready);
    // Station repeats the dropped ALU start
    @(negedge clk);
    ls_start = 1'b0;
    @(negedge clk);
    alu_start = 1'b0;
    compare("rob_done", 1, rob_done);
    compare("rob_dst", 20, rob_dst);
    compare("rob_value", 64'h1122_3344_5566_7788, rob_value);
    @(negedge clk);
    compare("rob_done", 1, rob_done);
    compare("rob_dst", 21, rob_dst);
    compare("rob_value", 16, rob_value);
    @(negedge clk);
    compare("rob_done", 0, rob_done);
    finish_test("arbitration");
  endtask

  initial begin
    rst_n = 1'b0;
    alu_start = 1'b0;
    ls_start = 1'b0;
    set_alu(FU_OP_PLUS, '0, '0, '0, 1'b0, '0, COND_AL);
    alu_start = 1'b0;
    set_ls(FU_OP_LDUR, '0, '0, '0);
    ls_start = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    test_arith();
    test_flag_pass();
    test_csel();
    test_memory();
    test_pipeline();
    test_arbitration();
    errors += u_dut.u_assertions.fail_count;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* func_units_assertions.sv */
`timescale 1ns/1ps

module func_units_assertions (
  input logic clk,
  input logic rst_n,
  input logic alu_start,
  input logic ls_start,
  input logic alu_ready,
  input logic rob_done
);

  // Number of assertion failures so far
  int fail_count = 0;

  // Synchronous reset clears the writeback valid
  assert property (@(posedge clk) !rst_n |=> !rob_done)
    else begin
      fail_count++;
      $error("rob_done high in the cycle after reset");
    end

  // Both paths have a fixed two-edge latency
  assert property (@(posedge clk) disable iff (!rst_n)
                   ((alu_start && alu_ready) || ls_start) |-> ##2 rob_done)
    else begin
      fail_count++;
      $error("rob_done missing two edges after an accepted start");
    end

  // Load/store owns the writeback slot
  assert property (@(posedge clk) !(ls_start && alu_ready))
    else begin
      fail_count++;
      $error("alu_ready high while ls_start is high");
    end

endmodule

bind func_units func_units_assertions u_assertions (.*);

/* func_units.sv */
`timescale 1ns/1ps

module func_units (
  input  logic             clk,
  input  logic             rst_n,
  // ALU reservation station
  input  logic             alu_start,
  input  fu_pkg::fu_op_t   alu_op,
  input  fu_pkg::gpr_t     alu_val_a,
  input  fu_pkg::gpr_t     alu_val_b,
  input  fu_pkg::rob_idx_t alu_dst,
  input  logic             alu_set_nzcv,
  input  fu_pkg::nzcv_t    alu_nzcv,
  input  fu_pkg::cond_t    alu_cond,
  // Load/store reservation station
  input  logic             ls_start,
  input  fu_pkg::fu_op_t   ls_op,
  input  fu_pkg::gpr_t     ls_val_a,
  input  fu_pkg::gpr_t     ls_val_b,
  input  fu_pkg::rob_idx_t ls_dst,
  output logic             alu_ready,
  output logic             ls_ready,
  // Shared ROB writeback
  output logic             rob_done,
  output fu_pkg::rob_idx_t rob_dst,
  output fu_pkg::gpr_t     rob_value,
  output fu_pkg::nzcv_t    rob_nzcv,
  output logic             rob_set_nzcv,
  output logic             rob_cond
);
  import fu_pkg::*;

  logic     alu_go;
  logic     ls_go;
  fu_op_t   ex_op;
  gpr_t     ex_val_a;
  gpr_t     ex_val_b;
  cond_t    ex_cond;
  nzcv_t    ex_nzcv;
  logic     ex_set_nzcv;
  rob_idx_t ex_dst;
  logic     mem_req;
  logic     mem_write;
  gpr_t     alu_result;
  nzcv_t    alu_flags;
  logic     alu_cond_holds;
  gpr_t     ls_rdata;

  fu_issue_decode u_decode (
    .clk          (clk),
    .rst_n        (rst_n),
    .alu_start    (alu_start),
    .alu_set_nzcv (alu_set_nzcv),
    .alu_op       (alu_op),
    .ls_op        (ls_op),
    .alu_val_a    (alu_val_a),
    .alu_val_b    (alu_val_b),
    .alu_dst      (alu_dst),
    .ls_dst       (ls_dst),
    .alu_nzcv     (alu_nzcv),
    .alu_cond     (alu_cond),
    .ls_start     (ls_start),
    .alu_ready    (alu_ready),
    .ls_ready     (ls_ready),
    .alu_go       (alu_go),
    .ls_go        (ls_go),
    .ex_op        (ex_op),
    .ex_val_a     (ex_val_a),
    .ex_val_b     (ex_val_b),
    .ex_cond      (ex_cond),
    .ex_nzcv      (ex_nzcv),
    .ex_set_nzcv  (ex_set_nzcv),
    .ex_dst       (ex_dst),
    .mem_req      (mem_req),
    .mem_write    (mem_write)
  );

  alu_exec u_alu (
    .op         (ex_op),
    .val_a      (ex_val_a),
    .val_b      (ex_val_b),
    .cond       (ex_cond),
    .nzcv_in    (ex_nzcv),
    .set_nzcv   (ex_set_nzcv),
    .result     (alu_result),
    .nzcv_out   (alu_flags),
    .cond_holds (alu_cond_holds)
  );

  // Address and store data bypass the decode registers
  ls_exec u_ls (
    .clk       (clk),
    .mem_req   (mem_req),
    .mem_write (mem_write),
    .addr      (ls_val_a),
    .wdata     (ls_val_b),
    .rdata     (ls_rdata)
  );

  fu_writeback u_writeback (
    .clk            (clk),
    .rst_n          (rst_n),
    .alu_go         (alu_go),
    .ls_go          (ls_go),
    .dst            (ex_dst),
    .alu_result     (alu_result),
    .ls_data        (ls_rdata),
    .alu_nzcv       (alu_flags),
    .alu_set_nzcv   (ex_set_nzcv),
    .alu_cond_holds (alu_cond_holds),
    .rob_done       (rob_done),
    .rob_dst        (rob_dst),
    .rob_value      (rob_value),
    .rob_nzcv       (rob_nzcv),
    .rob_set_nzcv   (rob_set_nzcv),
    .rob_cond       (rob_cond)
  );

endmodule

/* fu_writeback.sv */
`timescale 1ns/1ps

module fu_writeback (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             alu_go,
  input  logic             ls_go,
  input  fu_pkg::rob_idx_t dst,
  input  fu_pkg::gpr_t     alu_result,
  input  fu_pkg::gpr_t     ls_data,
  input  fu_pkg::nzcv_t    alu_nzcv,
  input  logic             alu_set_nzcv,
  input  logic             alu_cond_holds,
  output logic             rob_done,
  output fu_pkg::rob_idx_t rob_dst,
  output fu_pkg::gpr_t     rob_value,
  output fu_pkg::nzcv_t    rob_nzcv,
  output logic             rob_set_nzcv,
  output logic             rob_cond
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rob_done <= 1'b0;
    end else begin
      rob_done <= alu_go || ls_go;
    end
  end

  // At most one of the two go bits is set in any cycle
  always_ff @(posedge clk) begin
    if (ls_go) begin
      rob_dst <= dst;
      rob_value <= ls_data;
      rob_nzcv <= '0;
      rob_set_nzcv <= 1'b0;
      rob_cond <= 1'b0;
    end else if (alu_go) begin
      rob_dst <= dst;
      rob_value <= alu_result;
      rob_nzcv <= alu_nzcv;
      rob_set_nzcv <= alu_set_nzcv;
      rob_cond <= alu_cond_holds;
    end
  end

endmodule

/* ls_exec.sv */
`timescale 1ns/1ps

module ls_exec (
  input  logic         clk,
  input  logic         mem_req,
  input  logic         mem_write,
  input  fu_pkg::gpr_t addr,
  input  fu_pkg::gpr_t wdata,
  output fu_pkg::gpr_t rdata
);
  import fu_pkg::*;

  localparam int BYTES_PER_ACCESS = GPR_W / 8;

  logic [7:0] mem [DMEM_BYTES];

  // Per-byte addresses wrap around the end of memory
  logic [DMEM_ADDR_W-1:0] byte_addr [BYTES_PER_ACCESS];

  always_comb begin
    for (int k = 0; k < BYTES_PER_ACCESS; k++) begin
      byte_addr[k] = addr[DMEM_ADDR_W-1:0] + DMEM_ADDR_W'(k);
    end
  end

  // Little-endian, lowest byte at the base address
  always_ff @(posedge clk) begin
    if (mem_req && mem_write) begin
      for (int k = 0; k < BYTES_PER_ACCESS; k++) begin
        mem[byte_addr[k]] <= wdata[8*k +: 8];
      end
    end
  end

  // A store hands its own data back as the result
  always_ff @(posedge clk) begin
    if (mem_req) begin
      if (mem_write) begin
        rdata <= wdata;
      end else begin
        for (int k = 0; k < BYTES_PER_ACCESS; k++) begin
          rdata[8*k +: 8] <= mem[byte_addr[k]];
        end
      end
    end
  end

endmodule

/* alu_exec.sv */
`timescale 1ns/1ps

module alu_exec (
  input  fu_pkg::fu_op_t op,
  input  fu_pkg::gpr_t   val_a,
  input  fu_pkg::gpr_t   val_b,
  input  fu_pkg::cond_t  cond,
  input  fu_pkg::nzcv_t  nzcv_in,
  input  logic           set_nzcv,
  output fu_pkg::gpr_t   result,
  output fu_pkg::nzcv_t  nzcv_out,
  output logic           cond_holds
);
  import fu_pkg::*;

  logic [GPR_W:0] a_ext;
  logic [GPR_W:0] b_ext;
  logic [GPR_W:0] sum;
  logic [GPR_W:0] diff;
  logic           c_flag;
  logic           v_flag;

  // Condition is judged on the flags that came with the operation
  cond_check u_cond_check (
    .cond  (cond),
    .nzcv  (nzcv_in),
    .holds (cond_holds)
  );

  // One spare bit on top catches the carry
  assign a_ext = {1'b0, val_a};
  assign b_ext = {1'b0, val_b};
  assign sum = a_ext + b_ext;
  assign diff = a_ext - b_ext;

  always_comb begin
    c_flag = 1'b0;
    v_flag = 1'b0;
    case (op)
      FU_OP_PLUS: begin
        result = sum[GPR_W-1:0];
        c_flag = sum[GPR_W];
        v_flag = (val_a[GPR_W-1] == val_b[GPR_W-1]) &&
                 (sum[GPR_W-1] != val_a[GPR_W-1]);
      end
      FU_OP_MINUS: begin
        result = diff[GPR_W-1:0];
        // No borrow means a >= b
        c_flag = !diff[GPR_W];
        v_flag = (val_a[GPR_W-1] != val_b[GPR_W-1]) &&
                 (diff[GPR_W-1] != val_a[GPR_W-1]);
      end
      FU_OP_AND: result = val_a & val_b;
      FU_OP_OR: result = val_a | val_b;
      FU_OP_ORN: result = val_a | ~val_b;
      FU_OP_EOR: result = val_a ^ val_b;
      FU_OP_CSEL: result = cond_holds ? val_a : val_b;
      FU_OP_CSINC: result = cond_holds ? val_a : val_b + 1'b1;
      FU_OP_CSINV: result = cond_holds ? val_a : ~val_b;
      FU_OP_CSNEG: result = cond_holds ? val_a : ~val_b + 1'b1;
      // Plain OR, no shifted immediate
      FU_OP_MOV: result = val_a | val_b;
      default: result = '0;
    endcase

    if (set_nzcv) begin
      nzcv_out = {result[GPR_W-1], (result == '0), c_flag, v_flag};
    end else begin
      nzcv_out = nzcv_in;
    end
  end

endmodule

/* cond_check.sv */
`timescale 1ns/1ps

module cond_check (
  input  fu_pkg::cond_t cond,
  input  fu_pkg::nzcv_t nzcv,
  output logic          holds
);
  import fu_pkg::*;

  logic n_flag;
  logic z_flag;
  logic c_flag;
  logic v_flag;

  assign n_flag = nzcv[3];
  assign z_flag = nzcv[2];
  assign c_flag = nzcv[1];
  assign v_flag = nzcv[0];

  always_comb begin
    case (cond)
      COND_EQ: holds = z_flag;
      COND_NE: holds = !z_flag;
      COND_CS: holds = c_flag;
      COND_CC: holds = !c_flag;
      COND_MI: holds = n_flag;
      COND_PL: holds = !n_flag;
      COND_VS: holds = v_flag;
      COND_VC: holds = !v_flag;
      // Unsigned higher and lower-or-same
      COND_HI: holds = c_flag && !z_flag;
      COND_LS: holds = !c_flag || z_flag;
      // Signed compares
      COND_GE: holds = (n_flag == v_flag);
      COND_LT: holds = (n_flag != v_flag);
      COND_GT: holds = !z_flag && (n_flag == v_flag);
      COND_LE: holds = z_flag || (n_flag != v_flag);
      COND_AL: holds = 1'b1;
      // 4'b1111 also executes always on ARMv8
      default: holds = 1'b1;
    endcase
  end

endmodule

/* fu_issue_decode.sv */
`timescale 1ns/1ps

module fu_issue_decode (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             alu_start,
  input  logic             alu_set_nzcv,
  input  fu_pkg::fu_op_t   alu_op,
  input  fu_pkg::fu_op_t   ls_op,
  input  fu_pkg::gpr_t     alu_val_a,
  input  fu_pkg::gpr_t     alu_val_b,
  input  fu_pkg::rob_idx_t alu_dst,
  input  fu_pkg::rob_idx_t ls_dst,
  input  fu_pkg::nzcv_t    alu_nzcv,
  input  fu_pkg::cond_t    alu_cond,
  input  logic             ls_start,
  output logic             alu_ready,
  output logic             ls_ready,
  output logic             alu_go,
  output logic             ls_go,
  output fu_pkg::fu_op_t   ex_op,
  output fu_pkg::gpr_t     ex_val_a,
  output fu_pkg::gpr_t     ex_val_b,
  output fu_pkg::cond_t    ex_cond,
  output fu_pkg::nzcv_t    ex_nzcv,
  output logic             ex_set_nzcv,
  output fu_pkg::rob_idx_t ex_dst,
  output logic             mem_req,
  output logic             mem_write
);
  import fu_pkg::*;

  logic alu_accept;

  // Load/store always takes the shared writeback slot
  assign alu_accept = alu_start && !ls_start;
  assign alu_ready = !ls_start;
  assign ls_ready = 1'b1;

  // Memory is accessed in the start cycle itself
  assign mem_req = ls_start;
  assign mem_write = ls_start && (ls_op == FU_OP_STUR);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      alu_go <= 1'b0;
      ls_go <= 1'b0;
    end else begin
      alu_go <= alu_accept;
      ls_go <= ls_start;
    end
  end

  // Operand registers for the ALU stage
  always_ff @(posedge clk) begin
    if (alu_accept) begin
      ex_op <= alu_op;
      ex_val_a <= alu_val_a;
      ex_val_b <= alu_val_b;
      ex_cond <= alu_cond;
      ex_nzcv <= alu_nzcv;
      ex_set_nzcv <= alu_set_nzcv;
    end
    if (ls_start) begin
      ex_dst <= ls_dst;
    end else if (alu_accept) begin
      ex_dst <= alu_dst;
    end
  end

endmodule

/* fu_pkg.sv */
package fu_pkg;

  // Datapath widths
  localparam int GPR_W = 64;
  localparam int ROB_IDX_W = 6;

  // Data memory geometry
  localparam int DMEM_BYTES = 4096;
  localparam int DMEM_ADDR_W = $clog2(DMEM_BYTES);

  typedef logic [GPR_W-1:0] gpr_t;
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;

  // N is bit 3, Z bit 2, C bit 1, V bit 0
  typedef logic [3:0] nzcv_t;

  typedef logic [3:0] cond_t;
  typedef logic [3:0] fu_op_t;

  // Arithmetic and logic
  localparam fu_op_t FU_OP_PLUS = 4'd0;
  localparam fu_op_t FU_OP_MINUS = 4'd1;
  localparam fu_op_t FU_OP_AND = 4'd2;
  localparam fu_op_t FU_OP_OR = 4'd3;
  localparam fu_op_t FU_OP_ORN = 4'd4;
  localparam fu_op_t FU_OP_EOR = 4'd5;

  // Conditional selects
  localparam fu_op_t FU_OP_CSEL = 4'd6;
  localparam fu_op_t FU_OP_CSINC = 4'd7;
  localparam fu_op_t FU_OP_CSINV = 4'd8;
  localparam fu_op_t FU_OP_CSNEG = 4'd9;

  localparam fu_op_t FU_OP_MOV = 4'd10;

  // Load/store port only
  localparam fu_op_t FU_OP_LDUR = 4'd11;
  localparam fu_op_t FU_OP_STUR = 4'd12;

  // ARM condition field encodings
  localparam cond_t COND_EQ = 4'd0;
  localparam cond_t COND_NE = 4'd1;
  localparam cond_t COND_CS = 4'd2;
  localparam cond_t COND_CC = 4'd3;
  localparam cond_t COND_MI = 4'd4;
  localparam cond_t COND_PL = 4'd5;
  localparam cond_t COND_VS = 4'd6;
  localparam cond_t COND_VC = 4'd7;
  localparam cond_t COND_HI = 4'd8;
  localparam cond_t COND_LS = 4'd9;
  localparam cond_t COND_GE = 4'd10;
  localparam cond_t COND_LT = 4'd11;
  localparam cond_t COND_GT = 4'd12;
  localparam cond_t COND_LE = 4'd13;
  localparam cond_t COND_AL = 4'd14;

endpackage
